/* all.f */
+incdir+rtl
rtl/kcpu_pkg.sv
rtl/kcpu_opdec.sv
rtl/kcpu_ucode.sv
rtl/kcpu_exec.sv
rtl/kcpu_top.sv
sim/kcpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the kcpu testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module kcpu_tb -o kcpu_sim

out=$(./obj_dir/kcpu_sim)
echo "$out"
echo "$out" | grep -q "All checks passed"

/* sim/kcpu_tb.sv */
// kcpu random program testbench
`include "kcpu_consts.svh"

module kcpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // byte budget: 80 + 30 + 120 + 32 + 120 + 3, upper bounds per test
    localparam int max_bytes   = 385;
    localparam int cycle_limit = 20 * max_bytes + 200;

    logic               clk, rst, byte_stb, nmi_n, irq_n;
    logic [7:0]         byte_in, wr_data;
    logic               fetch_req, wr_stb, int_stb, bus_error;
    logic [3:0]         intvec;
    kcpu_pkg::reg_sel_t wr_reg;

    logic [31:0] rng = 32'd18;
    int          cycles = 0;
    int          max_dly, n_checks, n_errors, t_checks, t_errors;
    string       cur_test;
    logic [7:0]  regs [3];              // model a, b, x

    // expected events in order, writes and interrupt acks
    bit                 exp_is_int [$];
    kcpu_pkg::reg_sel_t exp_reg [$];
    logic [7:0]         exp_val [$];

    logic [7:0] imm_ops [11] = '{`KCPU_OP_LDA_IMM, `KCPU_OP_LDB_IMM, `KCPU_OP_LDX_IMM,
        `KCPU_OP_ADDA_IMM, `KCPU_OP_SUBA_IMM, `KCPU_OP_ANDA_IMM, `KCPU_OP_EORA_IMM,
        `KCPU_OP_ADDB_IMM, `KCPU_OP_SUBB_IMM, `KCPU_OP_ANDB_IMM, `KCPU_OP_EORB_IMM};
    logic [7:0] inh_ops [8] = '{`KCPU_OP_INCA, `KCPU_OP_DECA, `KCPU_OP_CLRA, `KCPU_OP_COMA,
        `KCPU_OP_INCB, `KCPU_OP_DECB, `KCPU_OP_CLRB, `KCPU_OP_COMB};
    logic [7:0] reg_ops [8] = '{`KCPU_OP_ADDA_R, `KCPU_OP_SUBA_R, `KCPU_OP_ANDA_R,
        `KCPU_OP_EORA_R, `KCPU_OP_ADDB_R, `KCPU_OP_SUBB_R, `KCPU_OP_ANDB_R, `KCPU_OP_EORB_R};

    kcpu_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .byte_stb  (byte_stb),
        .byte_in   (byte_in),
        .nmi_n     (nmi_n),
        .irq_n     (irq_n),
        .fetch_req (fetch_req),
        .wr_stb    (wr_stb),
        .wr_reg    (wr_reg),
        .wr_data   (wr_data),
        .int_stb   (int_stb),
        .intvec    (intvec),
        .bus_error (bus_error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: no progress within %0d cycles during %s", cycle_limit, cur_test);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] rnd();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic bit in_list8(input logic [7:0] op, input bit use_inh);
        foreach (inh_ops[i]) begin
            if (op == (use_inh ? inh_ops[i] : reg_ops[i])) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic bit is_imm_op(input logic [7:0] op);
        foreach (imm_ops[i]) begin
            if (op == imm_ops[i]) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic bit is_reg_op(input logic [7:0] op);
        return in_list8(op, 1'b0);
    endfunction

    function automatic bit is_legal(input logic [7:0] op);
        return is_imm_op(op) || in_list8(op, 1'b1) || is_reg_op(op) || op == `KCPU_OP_NOP;
    endfunction

    function automatic kcpu_pkg::reg_sel_t dest_of(input logic [7:0] op);
        case (op)
            `KCPU_OP_LDX_IMM: return kcpu_pkg::reg_x;
            `KCPU_OP_LDB_IMM, `KCPU_OP_ADDB_IMM, `KCPU_OP_SUBB_IMM, `KCPU_OP_ANDB_IMM,
            `KCPU_OP_EORB_IMM, `KCPU_OP_ADDB_R, `KCPU_OP_SUBB_R, `KCPU_OP_ANDB_R,
            `KCPU_OP_EORB_R, `KCPU_OP_INCB, `KCPU_OP_DECB, `KCPU_OP_CLRB,
            `KCPU_OP_COMB: return kcpu_pkg::reg_b;
            default: return kcpu_pkg::reg_a;
        endcase
    endfunction

    // d is the destination value, s the operand or source register
    function automatic logic [7:0] model_result(input logic [7:0] op, input logic [7:0] d,
                                               input logic [7:0] s);
        case (op)
            `KCPU_OP_LDA_IMM, `KCPU_OP_LDB_IMM, `KCPU_OP_LDX_IMM: return s;
            `KCPU_OP_ADDA_IMM, `KCPU_OP_ADDB_IMM, `KCPU_OP_ADDA_R, `KCPU_OP_ADDB_R: return d + s;
            `KCPU_OP_SUBA_IMM, `KCPU_OP_SUBB_IMM, `KCPU_OP_SUBA_R, `KCPU_OP_SUBB_R: return d - s;
            `KCPU_OP_ANDA_IMM, `KCPU_OP_ANDB_IMM, `KCPU_OP_ANDA_R, `KCPU_OP_ANDB_R: return d & s;
            `KCPU_OP_EORA_IMM, `KCPU_OP_EORB_IMM, `KCPU_OP_EORA_R, `KCPU_OP_EORB_R: return d ^ s;
            `KCPU_OP_INCA, `KCPU_OP_INCB: return d + 8'd1;
            `KCPU_OP_DECA, `KCPU_OP_DECB: return d - 8'd1;
            `KCPU_OP_CLRA, `KCPU_OP_CLRB: return 8'd0;
            default: return ~d;     // com
        endcase
    endfunction

    task automatic flag_error(input string msg);
        n_errors++;
        $display("%s", msg);
    endtask

    task automatic check_write(input kcpu_pkg::reg_sel_t exp_r, input logic [7:0] exp_d);
        n_checks++;
        if (wr_reg !== exp_r || wr_data !== exp_d) begin
            n_errors++;
            $display("Mismatch in %s: expected %s=%02h, actual %s=%02h",
                     cur_test, exp_r.name(), exp_d, wr_reg.name(), wr_data);
        end
    endtask

    task automatic check_int(input logic [3:0] exp_vec);
        n_checks++;
        if (intvec !== exp_vec) begin
            n_errors++;
            $display("Mismatch in %s: expected intvec=%04b, actual intvec=%04b",
                     cur_test, exp_vec, intvec);
        end
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin : monitor
        logic [7:0] v;
        if (wr_stb) begin
            if (exp_is_int.size() == 0 || exp_is_int[0]) begin
                flag_error($sformatf("unexpected register write of %02h to %s during %s",
                                     wr_data, wr_reg.name(), cur_test));
            end else begin
                void'(exp_is_int.pop_front());
                v = exp_val.pop_front();
                check_write(exp_reg.pop_front(), v);
            end
        end
        if (int_stb) begin
            if (exp_is_int.size() == 0 || !exp_is_int[0]) begin
                flag_error($sformatf("unexpected interrupt ack %04b during %s", intvec, cur_test));
            end else begin
                void'(exp_is_int.pop_front());
                void'(exp_reg.pop_front());
                v = exp_val.pop_front();
                check_int(v[3:0]);
            end
        end
    end

    task automatic expect_event(input bit is_int, input kcpu_pkg::reg_sel_t r,
                                input logic [7:0] v);
        exp_is_int.push_back(is_int);
        exp_reg.push_back(r);
        exp_val.push_back(v);
    endtask

    // strobe one byte, some cycles after the request shows up
    task automatic send_byte(input logic [7:0] b);
        int dly;
        dly = int'(rnd() % (max_dly + 1));
        @(negedge clk);
        while (!fetch_req) @(negedge clk);
        repeat (dly) @(negedge clk);
        @(posedge clk);
        byte_stb <= 1'b1;
        byte_in  <= b;
        @(posedge clk);
        byte_stb <= 1'b0;
    endtask

    task automatic pulse_ints();
        @(posedge clk);
        nmi_n <= 1'b0;
        irq_n <= 1'b0;
        repeat (2) @(posedge clk);
        nmi_n <= 1'b1;
        irq_n <= 1'b1;
    endtask

    task automatic run_op(input logic [7:0] op, input logic [7:0] arg, input bit intr);
        kcpu_pkg::reg_sel_t dst;
        logic [7:0]         src;
        dst = dest_of(op);
        src = is_reg_op(op) ? regs[arg[1:0]] : arg;
        if (op != `KCPU_OP_NOP) begin
            regs[dst] = model_result(op, regs[dst], src);
            expect_event(1'b0, dst, regs[dst]);
        end
        if (is_reg_op(op) && arg[7]) begin      // x post increment
            regs[kcpu_pkg::reg_x] = regs[kcpu_pkg::reg_x] + 8'd1;
            expect_event(1'b0, kcpu_pkg::reg_x, regs[kcpu_pkg::reg_x]);
        end
        if (intr) begin
            expect_event(1'b1, kcpu_pkg::reg_a, 8'h04);     // nmi first
            expect_event(1'b1, kcpu_pkg::reg_a, 8'h01);
        end
        send_byte(op);
        if (intr) pulse_ints();
        if (is_imm_op(op) || is_reg_op(op)) send_byte(arg);
    endtask

    // group 0 imm, 1 inherent, 2 register source, 3 nop
    task automatic random_op(input int group, input bit intr);
        logic [7:0] op, arg;
        case (group)
            0:       op = imm_ops[int'(rnd() % 11)];
            1:       op = inh_ops[int'(rnd() % 8)];
            2:       op = reg_ops[int'(rnd() % 8)];
            default: op = `KCPU_OP_NOP;
        endcase
        arg = 8'(rnd());
        if (group == 2) arg[1:0] = 2'(rnd() % 3);
        run_op(op, arg, intr);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        t_checks = n_checks;
        t_errors = n_errors;
    endtask

    task automatic end_test();
        while (exp_is_int.size() != 0) @(negedge clk);
        repeat (6) @(negedge clk);      // room for stray writes
        $display("test %-12s %0d checks, %0d errors", cur_test,
                 n_checks - t_checks, n_errors - t_errors);
    endtask

    // reset, one bad byte sequence, then watch the halt
    task automatic halt_case(input logic [7:0] op, input logic [7:0] pb);
        int waited;
        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        foreach (regs[i]) regs[i] = 8'd0;
        send_byte(op);
        if (is_reg_op(op)) send_byte(pb);
        waited = 0;
        while (!bus_error && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        n_checks++;
        if (!bus_error) flag_error($sformatf("bus_error never rose during %s", cur_test));
        repeat (20) begin
            @(negedge clk);
            n_checks++;
            if (fetch_req || !bus_error) begin
                flag_error($sformatf("halt not held during %s, fetch_req=%0b bus_error=%0b",
                                     cur_test, fetch_req, bus_error));
            end
        end
    endtask

    initial begin
        logic [7:0] op, pb;
        rst      = 1'b1;
        byte_stb = 1'b0;
        byte_in  = 8'd0;
        nmi_n    = 1'b1;
        irq_n    = 1'b1;
        n_checks = 0;
        n_errors = 0;
        max_dly  = 2;
        cur_test = "reset";
        foreach (regs[i]) regs[i] = 8'd0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        start_test("imm_alu");
        repeat (40) random_op(0, 1'b0);
        end_test();

        start_test("inherent");
        repeat (30) random_op(1, 1'b0);
        end_test();

        start_test("reg_source");
        repeat (30) begin
            if (rnd() % 4 == 0) random_op(0, 1'b0);     // fresh a, b or x now and then
            random_op(2, 1'b0);
        end
        end_test();

        start_test("interrupts");
        repeat (8) begin
            random_op(0, 1'b1);
            random_op(int'(rnd() % 3), 1'b0);
        end
        end_test();

        start_test("random_delay");
        max_dly = 7;
        repeat (60) random_op(int'(rnd() % 4), 1'b0);
        end_test();

        max_dly = 2;
        start_test("illegal_op");
        op = 8'(rnd());
        while (is_legal(op)) op = 8'(rnd());
        halt_case(op, 8'd0);
        end_test();

        start_test("illegal_pb");
        pb = 8'(rnd());
        pb[1:0] = 2'd3;
        halt_case(reg_ops[int'(rnd() % 8)], pb);
        end_test();

        $display("summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0 && n_checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* rtl/kcpu_top.sv */
// kcpu front end top
module kcpu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               byte_stb,
    input  logic [7:0]         byte_in,
    input  logic               nmi_n,
    input  logic               irq_n,
    output logic               fetch_req,
    output logic               wr_stb,
    output kcpu_pkg::reg_sel_t wr_reg,
    output logic [7:0]         wr_data,
    output logic               int_stb,
    output logic [3:0]         intvec,
    output logic               bus_error
);

    kcpu_pkg::opcat_t   cat;
    kcpu_pkg::alu_op_t  alu_op_d, alu_op;
    kcpu_pkg::reg_sel_t dst_d, dst_sel;
    kcpu_pkg::reg_sel_t pb_src, src_sel;      // postbyte field, then aligned copy
    logic [7:0]         operand;
    logic               pb_inc, post_inc, post_bad;
    logic               byte_done, want_op;
    logic               alu_go, use_operand;

    // stage 1, byte latch and decode
    kcpu_opdec u_opdec (
        .clk       (clk),
        .rst       (rst),
        .byte_stb  (byte_stb),
        .byte_in   (byte_in),
        .want_op   (want_op),
        .cat       (cat),
        .alu_op_d  (alu_op_d),
        .dst_d     (dst_d),
        .operand   (operand),
        .src_sel   (pb_src),
        .post_inc  (pb_inc),
        .post_bad  (post_bad),
        .byte_done (byte_done)
    );

    // stage 2
    kcpu_ucode u_ucode (
        .clk         (clk),
        .rst         (rst),
        .cat         (cat),
        .alu_op_d    (alu_op_d),
        .dst_d       (dst_d),
        .src_sel_in  (pb_src),
        .post_inc_in (pb_inc),
        .post_bad    (post_bad),
        .byte_done   (byte_done),
        .nmi_n       (nmi_n),
        .irq_n       (irq_n),
        .want_op     (want_op),
        .fetch_req   (fetch_req),
        .alu_go      (alu_go),
        .alu_op      (alu_op),
        .dst_sel     (dst_sel),
        .src_sel     (src_sel),
        .use_operand (use_operand),
        .post_inc    (post_inc),
        .int_stb     (int_stb),
        .intvec      (intvec),
        .bus_error   (bus_error)
    );

    // stage 3, overlaps the next opcode fetch
    kcpu_exec u_exec (
        .clk         (clk),
        .rst         (rst),
        .alu_go      (alu_go),
        .alu_op      (alu_op),
        .dst_sel     (dst_sel),
        .src_sel     (src_sel),
        .use_operand (use_operand),
        .post_inc    (post_inc),
        .operand     (operand),
        .wr_stb      (wr_stb),
        .wr_reg      (wr_reg),
        .wr_data     (wr_data)
    );

endmodule

/* rtl/kcpu_exec.sv */
// register file and alu
module kcpu_exec (
    input  logic               clk,
    input  logic               rst,
    input  logic               alu_go,
    input  kcpu_pkg::alu_op_t  alu_op,
    input  kcpu_pkg::reg_sel_t dst_sel,
    input  kcpu_pkg::reg_sel_t src_sel,
    input  logic               use_operand,
    input  logic               post_inc,
    input  logic [7:0]         operand,
    output logic               wr_stb,
    output kcpu_pkg::reg_sel_t wr_reg,
    output logic [7:0]         wr_data
);

    logic [7:0] a_q, b_q, x_q;
    logic [7:0] dst_val, src_val, opnd, result;
    logic       inc_pend;           // x+1 write due next cycle

    always_comb begin
        case (dst_sel)
            kcpu_pkg::reg_a: dst_val = a_q;
            kcpu_pkg::reg_b: dst_val = b_q;
            default:         dst_val = x_q;
        endcase
        case (src_sel)
            kcpu_pkg::reg_a: src_val = a_q;
            kcpu_pkg::reg_b: src_val = b_q;
            default:         src_val = x_q;
        endcase
        opnd = use_operand ? operand : src_val;
        case (alu_op)
            kcpu_pkg::alu_ld:  result = opnd;
            kcpu_pkg::alu_add: result = dst_val + opnd;   // wraps mod 256
            kcpu_pkg::alu_sub: result = dst_val - opnd;
            kcpu_pkg::alu_and: result = dst_val & opnd;
            kcpu_pkg::alu_eor: result = dst_val ^ opnd;
            kcpu_pkg::alu_inc: result = dst_val + 8'd1;
            kcpu_pkg::alu_dec: result = dst_val - 8'd1;
            kcpu_pkg::alu_clr: result = 8'd0;
            default:           result = ~dst_val;         // com
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            a_q      <= 8'd0;
            b_q      <= 8'd0;
            x_q      <= 8'd0;
            wr_stb   <= 1'b0;
            inc_pend <= 1'b0;
        end else begin
            wr_stb   <= 1'b0;
            inc_pend <= 1'b0;
            if (alu_go) begin
                case (dst_sel)
                    kcpu_pkg::reg_a: a_q <= result;
                    kcpu_pkg::reg_b: b_q <= result;
                    default:         x_q <= result;
                endcase
                wr_stb   <= 1'b1;
                inc_pend <= post_inc;
            end else if (inc_pend) begin
                x_q    <= x_q + 8'd1;
                wr_stb <= 1'b1;
            end
        end
    end

    // write report, same timing as the register update
    always_ff @(posedge clk) begin
        if (alu_go) begin
            wr_reg  <= dst_sel;
            wr_data <= result;
        end else if (inc_pend) begin
            wr_reg  <= kcpu_pkg::reg_x;
            wr_data <= x_q + 8'd1;
        end
    end

    // spacing comes from the alu_reg routine in the sequencer
    a_no_go_on_inc: assert property (@(posedge clk) disable iff (rst)
        alu_go |-> !inc_pend);

endmodule

/* rtl/kcpu_ucode.sv */
// microcode sequencer
`include "kcpu_consts.svh"

module kcpu_ucode (
    input  logic               clk,
    input  logic               rst,
    input  kcpu_pkg::opcat_t   cat,
    input  kcpu_pkg::alu_op_t  alu_op_d,
    input  kcpu_pkg::reg_sel_t dst_d,
    input  kcpu_pkg::reg_sel_t src_sel_in,
    input  logic               post_inc_in,
    input  logic               post_bad,
    input  logic               byte_done,
    input  logic               nmi_n,
    input  logic               irq_n,
    output logic               want_op,
    output logic               fetch_req,
    output logic               alu_go,
    output kcpu_pkg::alu_op_t  alu_op,
    output kcpu_pkg::reg_sel_t dst_sel,
    output kcpu_pkg::reg_sel_t src_sel,
    output logic               use_operand,
    output logic               post_inc,
    output logic               int_stb,
    output logic [3:0]         intvec,
    output logic               bus_error
);

    // {wait_byte, byte_is_op, go, from_post, ni, ack}
    localparam logic [`KCPU_UCODE_DW-1:0] row_idle    = 6'b000000;
    localparam logic [`KCPU_UCODE_DW-1:0] row_ni      = 6'b110010;
    localparam logic [`KCPU_UCODE_DW-1:0] row_wait    = 6'b100000;
    localparam logic [`KCPU_UCODE_DW-1:0] row_go      = 6'b001000;
    localparam logic [`KCPU_UCODE_DW-1:0] row_go_post = 6'b001100;
    localparam logic [`KCPU_UCODE_DW-1:0] row_ack     = 6'b000001;

    logic [`KCPU_UCODE_AW-1:0] addr;
    logic [`KCPU_UCODE_DW-1:0] row;
    kcpu_pkg::opcat_t          cur_cat;
    logic wait_byte, byte_is_op, go, from_post, ni, ack;
    logic in_wait;                  // boundary committed to the next opcode
    logic nmi_q, irq_q, nmi_pend, irq_pend;
    logic int_hold;

    assign cur_cat = kcpu_pkg::opcat_t'(addr[`KCPU_UCODE_AW-1:`KCPU_STEP_AW]);

    // routine table
    always_comb begin
        case (addr)
            {kcpu_pkg::reset_ent, 2'd0}: row = row_idle;
            {kcpu_pkg::reset_ent, 2'd1}: row = row_ni;
            {kcpu_pkg::alu_imm,   2'd0}: row = row_wait;     // operand
            {kcpu_pkg::alu_imm,   2'd1}: row = row_go;
            {kcpu_pkg::alu_imm,   2'd2}: row = row_ni;
            {kcpu_pkg::ld_imm,    2'd0}: row = row_wait;
            {kcpu_pkg::ld_imm,    2'd1}: row = row_go;
            {kcpu_pkg::ld_imm,    2'd2}: row = row_ni;
            {kcpu_pkg::alu_inh,   2'd0}: row = row_go;
            {kcpu_pkg::alu_inh,   2'd1}: row = row_ni;
            {kcpu_pkg::alu_reg,   2'd0}: row = row_wait;     // postbyte
            {kcpu_pkg::alu_reg,   2'd1}: row = row_go_post;
            {kcpu_pkg::alu_reg,   2'd2}: row = row_idle;     // room for the x+1 write
            {kcpu_pkg::alu_reg,   2'd3}: row = row_ni;
            {kcpu_pkg::nope,      2'd0}: row = row_ni;
            {kcpu_pkg::nmi_ent,   2'd0}: row = row_ack;
            {kcpu_pkg::nmi_ent,   2'd1}: row = row_ni;
            {kcpu_pkg::irq_ent,   2'd0}: row = row_ack;
            {kcpu_pkg::irq_ent,   2'd1}: row = row_ni;
            default:                     row = row_idle;     // buserr never leaves
        endcase
    end

    assign wait_byte  = row[`KCPU_UC_WAIT];
    assign byte_is_op = row[`KCPU_UC_ISOP];
    assign go         = row[`KCPU_UC_GO];
    assign from_post  = row[`KCPU_UC_POST];
    assign ni         = row[`KCPU_UC_NI];
    assign ack        = row[`KCPU_UC_ACK];

    // boundary with a pending interrupt does not ask for a byte
    assign int_hold  = ni && !in_wait && (nmi_pend || irq_pend);
    assign want_op   = byte_is_op;
    assign fetch_req = wait_byte && !byte_done && !int_hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr      <= {kcpu_pkg::reset_ent, 2'd0};
            in_wait   <= 1'b0;
            nmi_q     <= 1'b1;
            irq_q     <= 1'b1;
            nmi_pend  <= 1'b0;
            irq_pend  <= 1'b0;
            alu_go    <= 1'b0;
            int_stb   <= 1'b0;
            intvec    <= 4'd0;
            bus_error <= 1'b0;
        end else begin
            alu_go  <= 1'b0;
            int_stb <= 1'b0;
            intvec  <= 4'd0;
            if (!bus_error) begin
                alu_go  <= go;
                int_stb <= ack;
                if (ack) begin
                    intvec <= {1'b0, cur_cat == kcpu_pkg::nmi_ent,
                               1'b0, cur_cat == kcpu_pkg::irq_ent};
                end
                if (ni) begin
                    if (byte_done) begin
                        addr    <= {cat, 2'd0};
                        in_wait <= 1'b0;
                        if (cat == kcpu_pkg::buserr) bus_error <= 1'b1;
                    end else if (!in_wait && nmi_pend) begin
                        addr     <= {kcpu_pkg::nmi_ent, 2'd0};   // nmi first
                        nmi_pend <= 1'b0;
                    end else if (!in_wait && irq_pend) begin
                        addr     <= {kcpu_pkg::irq_ent, 2'd0};
                        irq_pend <= 1'b0;
                    end else begin
                        in_wait <= 1'b1;
                    end
                end else if (wait_byte) begin
                    if (byte_done) begin
                        addr <= addr + 1'b1;
                        if (cur_cat == kcpu_pkg::alu_reg && post_bad) bus_error <= 1'b1;
                    end
                end else begin
                    addr <= addr + 1'b1;
                end
            end
            // falling edge detect
            // a fresh edge beats a same-cycle clear
            nmi_q <= nmi_n;
            irq_q <= irq_n;
            if (nmi_q && !nmi_n) nmi_pend <= 1'b1;
            if (irq_q && !irq_n) irq_pend <= 1'b1;
        end
    end

    // operation fields travel with alu_go
    always_ff @(posedge clk) begin
        if (go) begin
            alu_op      <= alu_op_d;
            dst_sel     <= dst_d;
            src_sel     <= src_sel_in;
            use_operand <= !from_post;
            post_inc    <= post_inc_in && from_post;
        end
    end

    a_no_fetch_halted: assert property (@(posedge clk) disable iff (rst)
        !(fetch_req && bus_error));
    a_int_onehot: assert property (@(posedge clk) disable iff (rst)
        int_stb |-> $onehot(intvec));

endmodule

/* rtl/kcpu_opdec.sv */
// opcode and operand latch
`include "kcpu_consts.svh"

module kcpu_opdec (
    input  logic               clk,
    input  logic               rst,
    input  logic               byte_stb,
    input  logic [7:0]         byte_in,
    input  logic               want_op,
    output kcpu_pkg::opcat_t   cat,
    output kcpu_pkg::alu_op_t  alu_op_d,
    output kcpu_pkg::reg_sel_t dst_d,
    output logic [7:0]         operand,
    output kcpu_pkg::reg_sel_t src_sel,
    output logic               post_inc,
    output logic               post_bad,
    output logic               byte_done
);

    kcpu_pkg::opcat_t   dec_cat;
    kcpu_pkg::alu_op_t  dec_op;
    kcpu_pkg::reg_sel_t dec_dst;

    // opcode to category, alu op and destination
    always_comb begin
        dec_cat = kcpu_pkg::alu_imm;
        dec_op  = kcpu_pkg::alu_ld;
        dec_dst = kcpu_pkg::reg_a;
        case (byte_in)
            `KCPU_OP_LDA_IMM:  dec_cat = kcpu_pkg::ld_imm;
            `KCPU_OP_LDB_IMM: begin
                dec_cat = kcpu_pkg::ld_imm;
                dec_dst = kcpu_pkg::reg_b;
            end
            `KCPU_OP_LDX_IMM: begin
                dec_cat = kcpu_pkg::ld_imm;
                dec_dst = kcpu_pkg::reg_x;
            end
            `KCPU_OP_ADDA_IMM: dec_op = kcpu_pkg::alu_add;
            `KCPU_OP_SUBA_IMM: dec_op = kcpu_pkg::alu_sub;
            `KCPU_OP_ANDA_IMM: dec_op = kcpu_pkg::alu_and;
            `KCPU_OP_EORA_IMM: dec_op = kcpu_pkg::alu_eor;
            `KCPU_OP_ADDB_IMM,
            `KCPU_OP_SUBB_IMM,
            `KCPU_OP_ANDB_IMM,
            `KCPU_OP_EORB_IMM: begin
                dec_dst = kcpu_pkg::reg_b;
                case (byte_in[3:0])
                    4'hB:    dec_op = kcpu_pkg::alu_add;
                    4'h0:    dec_op = kcpu_pkg::alu_sub;
                    4'h4:    dec_op = kcpu_pkg::alu_and;
                    default: dec_op = kcpu_pkg::alu_eor;
                endcase
            end
            `KCPU_OP_ADDA_R, `KCPU_OP_SUBA_R, `KCPU_OP_ANDA_R, `KCPU_OP_EORA_R,
            `KCPU_OP_ADDB_R, `KCPU_OP_SUBB_R, `KCPU_OP_ANDB_R, `KCPU_OP_EORB_R: begin
                dec_cat = kcpu_pkg::alu_reg;
                dec_dst = byte_in[2] ? kcpu_pkg::reg_b : kcpu_pkg::reg_a;
                dec_op  = kcpu_pkg::alu_op_t'({2'b00, byte_in[1:0]} + 4'd1); // add..eor
            end
            `KCPU_OP_INCA, `KCPU_OP_DECA, `KCPU_OP_CLRA, `KCPU_OP_COMA,
            `KCPU_OP_INCB, `KCPU_OP_DECB, `KCPU_OP_CLRB, `KCPU_OP_COMB: begin
                dec_cat = kcpu_pkg::alu_inh;
                dec_dst = byte_in[4] ? kcpu_pkg::reg_b : kcpu_pkg::reg_a;
                case (byte_in[3:0])
                    4'hC:    dec_op = kcpu_pkg::alu_inc;
                    4'hA:    dec_op = kcpu_pkg::alu_dec;
                    4'hF:    dec_op = kcpu_pkg::alu_clr;
                    default: dec_op = kcpu_pkg::alu_com;
                endcase
            end
            `KCPU_OP_NOP:      dec_cat = kcpu_pkg::nope;
            default:           dec_cat = kcpu_pkg::buserr;    // halts the sequencer
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cat       <= kcpu_pkg::nope;
            post_bad  <= 1'b0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= byte_stb;
            if (byte_stb && want_op) begin
                cat <= dec_cat;
            end else if (byte_stb) begin
                post_bad <= byte_in[`KCPU_PB_SRC_MSB:`KCPU_PB_SRC_LSB] == `KCPU_PB_SRC_BAD;
            end
        end
    end

    // payload is only meaningful once byte_done was seen
    always_ff @(posedge clk) begin
        if (byte_stb && want_op) begin
            alu_op_d <= dec_op;
            dst_d    <= dec_dst;
        end else if (byte_stb) begin
            operand  <= byte_in;    // same byte doubles as postbyte
            src_sel  <= kcpu_pkg::reg_sel_t'(byte_in[`KCPU_PB_SRC_MSB:`KCPU_PB_SRC_LSB]);
            post_inc <= byte_in[`KCPU_PB_POSTINC];
        end
    end

    // the sequencer must drive want_op before any byte shows up
    a_want_op_known: assert property (@(posedge clk) disable iff (rst)
        byte_stb |-> !$isunknown(want_op));

endmodule

/* rtl/kcpu_pkg.sv */
// kcpu shared types
`include "kcpu_consts.svh"

package kcpu_pkg;

    // microcode categories, each owns one routine in the table
    typedef enum logic [`KCPU_OPCAT_AW-1:0] {
        alu_imm   = 4'd0,
        alu_inh   = 4'd1,
        alu_reg   = 4'd2,
        ld_imm    = 4'd3,
        nope      = 4'd4,
        nmi_ent   = 4'd5,
        irq_ent   = 4'd6,
        buserr    = 4'd7,
        reset_ent = 4'd8
    } opcat_t;

    // alu operations
    typedef enum logic [3:0] {
        alu_ld  = 4'd0,     // result = source
        alu_add = 4'd1,
        alu_sub = 4'd2,
        alu_and = 4'd3,
        alu_eor = 4'd4,
        alu_inc = 4'd5,
        alu_dec = 4'd6,
        alu_clr = 4'd7,
        alu_com = 4'd8
    } alu_op_t;

    // byte registers
    typedef enum logic [1:0] {
        reg_a = 2'd0,
        reg_b = 2'd1,
        reg_x = 2'd2
    } reg_sel_t;

endpackage

/* rtl/kcpu_consts.svh */
// kcpu shared constants
`ifndef KCPU_CONSTS_SVH
`define KCPU_CONSTS_SVH

// microcode address = {category, step}
`define KCPU_UCODE_AW 6
`define KCPU_OPCAT_AW 4
`define KCPU_STEP_AW  2     // 4 rows per routine

// routine row fields, {wait_byte, byte_is_op, go, from_post, ni, ack}
`define KCPU_UCODE_DW 6
`define KCPU_UC_WAIT  5
`define KCPU_UC_ISOP  4
`define KCPU_UC_GO    3
`define KCPU_UC_POST  2
`define KCPU_UC_NI    1
`define KCPU_UC_ACK   0

// immediate loads
`define KCPU_OP_LDA_IMM  8'h86
`define KCPU_OP_LDB_IMM  8'hC6
`define KCPU_OP_LDX_IMM  8'h8E

// immediate alu ops
`define KCPU_OP_ADDA_IMM 8'h8B
`define KCPU_OP_SUBA_IMM 8'h80
`define KCPU_OP_ANDA_IMM 8'h84
`define KCPU_OP_EORA_IMM 8'h88
`define KCPU_OP_ADDB_IMM 8'hCB
`define KCPU_OP_SUBB_IMM 8'hC0
`define KCPU_OP_ANDB_IMM 8'hC4
`define KCPU_OP_EORB_IMM 8'hC8

// register source ops, a postbyte follows
`define KCPU_OP_ADDA_R   8'h30
`define KCPU_OP_SUBA_R   8'h31
`define KCPU_OP_ANDA_R   8'h32
`define KCPU_OP_EORA_R   8'h33
`define KCPU_OP_ADDB_R   8'h34
`define KCPU_OP_SUBB_R   8'h35
`define KCPU_OP_ANDB_R   8'h36
`define KCPU_OP_EORB_R   8'h37

// inherent
`define KCPU_OP_INCA     8'h4C
`define KCPU_OP_DECA     8'h4A
`define KCPU_OP_CLRA     8'h4F
`define KCPU_OP_COMA     8'h43
`define KCPU_OP_INCB     8'h5C
`define KCPU_OP_DECB     8'h5A
`define KCPU_OP_CLRB     8'h5F
`define KCPU_OP_COMB     8'h53
`define KCPU_OP_NOP      8'h12

// postbyte layout
`define KCPU_PB_SRC_MSB  1
`define KCPU_PB_SRC_LSB  0
`define KCPU_PB_POSTINC  7
`define KCPU_PB_SRC_BAD  2'd3   // no fourth register

`endif
